// ==== dram_config.svh ====
`ifndef DRAM_CONFIG_SVH
`define DRAM_CONFIG_SVH

// channel count and channel byte-address width
`define DRAM_NUM_CH 2
`define DRAM_ADDR_W 16

// data word and byte mask
`define DRAM_DATA_W 32
`define DRAM_MASK_W (`DRAM_DATA_W / 8)
`define DRAM_OFFSET_W 2

// word address split: col, then bank, row takes the rest
`define DRAM_COL_W 4
`define DRAM_BANK_W 2
`define DRAM_ROW_W (`DRAM_ADDR_W - `DRAM_OFFSET_W - `DRAM_COL_W - `DRAM_BANK_W)

// access latencies in cycles
`define DRAM_T_HIT 4
`define DRAM_T_MISS 10

`define DRAM_QUEUE_DEPTH 4
`define DRAM_CNT_W 16
`define DRAM_CYC_W 32

`endif

// ==== dram_pkg.sv ====
`default_nettype none

`include "dram_config.svh"

package dram_pkg;

  typedef struct packed {
    logic                     wnr;
    logic [`DRAM_ADDR_W-1:0]  addr;
    logic [`DRAM_DATA_W-1:0]  data;
    logic [`DRAM_MASK_W-1:0]  mask;
  } dram_req_t;

  typedef struct packed {
    logic [`DRAM_ROW_W-1:0]   row;
    logic [`DRAM_BANK_W-1:0]  bank;
    logic [`DRAM_COL_W-1:0]   col;
  } dram_loc_t;

  typedef struct packed {
    logic                     wnr;
    logic [`DRAM_ADDR_W-1:0]  addr;
  } dram_done_t;

  typedef struct packed {
    logic [`DRAM_CNT_W-1:0]   reads;
    logic [`DRAM_CNT_W-1:0]   writes;
    logic [`DRAM_CNT_W-1:0]   hits;
  } dram_stats_t;

  typedef enum logic {
    e_bank_closed,
    e_bank_open
  } bank_state_e;

  // byte offset dropped, col sits lowest in the word address
  function automatic dram_loc_t dram_decode(input logic [`DRAM_ADDR_W-1:0] addr);
    dram_loc_t loc;
    loc.col  = addr[`DRAM_OFFSET_W +: `DRAM_COL_W];
    loc.bank = addr[`DRAM_OFFSET_W + `DRAM_COL_W +: `DRAM_BANK_W];
    loc.row  = addr[`DRAM_ADDR_W-1 -: `DRAM_ROW_W];
    return loc;
  endfunction

endpackage

`default_nettype wire

// ==== dram_channel_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dram_config.svh"

module dram_channel_timing
  import dram_pkg::*;
  (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       v_i,
  input  logic       data_v_i,
  input  dram_req_t  req_i,
  output logic       yumi_o,
  output logic       hit_o,
  output logic       done_v_o,
  output dram_done_t done_o
);

  localparam int NUM_BANKS = 1 << `DRAM_BANK_W;
  localparam int DEPTH     = `DRAM_QUEUE_DEPTH;
  localparam int QPTR_W    = $clog2(DEPTH);
  localparam int QCNT_W    = $clog2(DEPTH + 1);

  dram_loc_t               loc;
  logic                    full;
  logic                    push;
  logic                    pop;
  logic [`DRAM_CYC_W-1:0]  lat;
  logic [`DRAM_CYC_W-1:0]  due_at;
  logic [`DRAM_CYC_W-1:0]  cycle_r;
  logic [`DRAM_CYC_W-1:0]  last_due_r;

  bank_state_e             bank_state_r [NUM_BANKS];
  logic [`DRAM_ROW_W-1:0]  open_row_r [NUM_BANKS];

  dram_done_t              q_done_r [DEPTH];
  logic [`DRAM_CYC_W-1:0]  q_due_r [DEPTH];
  logic [QPTR_W-1:0]       wr_ptr_r;
  logic [QPTR_W-1:0]       rd_ptr_r;
  logic [QCNT_W-1:0]       count_r;

  assign loc   = dram_decode(req_i.addr);
  assign hit_o = (bank_state_r[loc.bank] == e_bank_open) && (open_row_r[loc.bank] == loc.row);

  // writes also wait for their data
  assign full   = (count_r == QCNT_W'(DEPTH));
  assign yumi_o = v_i & ~full & (~req_i.wnr | data_v_i);
  assign push   = yumi_o;

  assign lat = hit_o ? `DRAM_CYC_W'(`DRAM_T_HIT) : `DRAM_CYC_W'(`DRAM_T_MISS);

  // keep completions strictly ordered, one per cycle
  always_comb begin
    due_at = cycle_r + lat;
    if (last_due_r + 1'b1 > due_at) begin
      due_at = last_due_r + 1'b1;
    end
  end

  assign done_v_o = (count_r != '0) && (q_due_r[rd_ptr_r] == cycle_r);
  assign done_o   = q_done_r[rd_ptr_r];
  assign pop      = done_v_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cycle_r    <= '0;
      last_due_r <= '0;
      wr_ptr_r   <= '0;
      rd_ptr_r   <= '0;
      count_r    <= '0;
      for (int b = 0; b < NUM_BANKS; b++) begin
        bank_state_r[b] <= e_bank_closed;
      end
    end else begin
      cycle_r <= cycle_r + 1'b1;
      if (push) begin
        last_due_r             <= due_at;
        bank_state_r[loc.bank] <= e_bank_open;
        wr_ptr_r <= (wr_ptr_r == QPTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == QPTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // queue payload and open rows, qualified by bank state
  always_ff @(posedge clk_i) begin
    if (push) begin
      open_row_r[loc.bank] <= loc.row;
      q_done_r[wr_ptr_r]   <= '{wnr: req_i.wnr, addr: req_i.addr};
      q_due_r[wr_ptr_r]    <= due_at;
    end
  end

  // a push into a full queue would break the pointer distance
  a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
    (count_r <= QCNT_W'(DEPTH)) &&
    ((int'(wr_ptr_r) - int'(rd_ptr_r) + DEPTH) % DEPTH == int'(count_r) % DEPTH));

  a_no_done_in_reset: assert property (@(posedge clk_i)
    (reset_i && $past(reset_i)) |-> !done_v_o);

  // a late head would never pop and would stall the channel
  a_head_not_late: assert property (@(posedge clk_i) disable iff (reset_i)
    (count_r != '0) |-> (q_due_r[rd_ptr_r] >= cycle_r));

endmodule

`default_nettype wire

// ==== dram_channel_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dram_config.svh"

module dram_channel_mem (
  input  logic                    clk_i,
  input  logic                    w_v_i,
  input  logic [`DRAM_ADDR_W-1:0] w_addr_i,
  input  logic [`DRAM_DATA_W-1:0] w_data_i,
  input  logic [`DRAM_MASK_W-1:0] w_mask_i,
  input  logic                    r_v_i,
  input  logic [`DRAM_ADDR_W-1:0] r_addr_i,
  output logic [`DRAM_DATA_W-1:0] r_data_o
);

  localparam int WORD_W = `DRAM_ADDR_W - `DRAM_OFFSET_W;
  localparam int WORDS  = 1 << WORD_W;

  logic [`DRAM_DATA_W-1:0] mem_r [WORDS];
  logic [WORD_W-1:0]       w_word;
  logic [WORD_W-1:0]       r_word;

  // word index, byte offset dropped
  assign w_word = w_addr_i[`DRAM_ADDR_W-1:`DRAM_OFFSET_W];
  assign r_word = r_addr_i[`DRAM_ADDR_W-1:`DRAM_OFFSET_W];

  always_ff @(posedge clk_i) begin
    if (w_v_i) begin
      for (int b = 0; b < `DRAM_MASK_W; b++) begin
        if (w_mask_i[b]) begin
          mem_r[w_word][8*b +: 8] <= w_data_i[8*b +: 8];
        end
      end
    end
    // old word wins on a same-cycle write
    if (r_v_i) begin
      r_data_o <= mem_r[r_word];
    end
  end

endmodule

`default_nettype wire

// ==== dram_channel_stats.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dram_config.svh"

module dram_channel_stats
  import dram_pkg::*;
  (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        accept_i,
  input  logic        write_i,
  input  logic        hit_i,
  input  logic        stat_v_i,
  output dram_stats_t stats_o
);

  logic [`DRAM_CNT_W-1:0] reads_r;
  logic [`DRAM_CNT_W-1:0] writes_r;
  logic [`DRAM_CNT_W-1:0] hits_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reads_r  <= '0;
      writes_r <= '0;
      hits_r   <= '0;
      stats_o  <= '0;
    end else begin
      if (accept_i) begin
        if (write_i) begin
          writes_r <= writes_r + 1'b1;
        end else begin
          reads_r <= reads_r + 1'b1;
        end
        if (hit_i) begin
          hits_r <= hits_r + 1'b1;
        end
      end
      // snapshot leaves out this cycle's acceptance
      if (stat_v_i) begin
        stats_o <= '{reads: reads_r, writes: writes_r, hits: hits_r};
      end
    end
  end

  a_no_wrap_rw: assert property (@(posedge clk_i) disable iff (reset_i)
    accept_i |-> (write_i ? (writes_r != '1) : (reads_r != '1)));

  a_no_wrap_hit: assert property (@(posedge clk_i) disable iff (reset_i)
    (accept_i && hit_i) |-> (hits_r != '1));

endmodule

`default_nettype wire

// ==== dram_model.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dram_config.svh"

module dram_model
  import dram_pkg::*;
  (
  input  logic                                       clk_i,
  input  logic                                       reset_i,

  input  logic        [`DRAM_NUM_CH-1:0]                   v_i,
  input  logic        [`DRAM_NUM_CH-1:0]                   data_v_i,
  input  dram_req_t   [`DRAM_NUM_CH-1:0]                   req_i,
  output logic        [`DRAM_NUM_CH-1:0]                   yumi_o,

  output logic        [`DRAM_NUM_CH-1:0]                   read_done_o,
  output logic        [`DRAM_NUM_CH-1:0]                   write_done_o,
  output logic        [`DRAM_NUM_CH-1:0][`DRAM_ADDR_W-1:0] done_addr_o,

  output logic        [`DRAM_NUM_CH-1:0]                   data_v_o,
  output logic        [`DRAM_NUM_CH-1:0][`DRAM_DATA_W-1:0] data_o,
  output logic        [`DRAM_NUM_CH-1:0][`DRAM_ADDR_W-1:0] read_addr_o,

  input  logic                                       stat_v_i,
  output dram_stats_t [`DRAM_NUM_CH-1:0]                   stats_o
);

  for (genvar i = 0; i < `DRAM_NUM_CH; i++) begin : g_ch
    dram_done_t done_lo;
    logic       done_v_lo;
    logic       hit_lo;
    logic       write_v_li;

    dram_channel_timing i_timing (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .v_i      (v_i[i]),
      .data_v_i (data_v_i[i]),
      .req_i    (req_i[i]),
      .yumi_o   (yumi_o[i]),
      .hit_o    (hit_lo),
      .done_v_o (done_v_lo),
      .done_o   (done_lo)
    );

    // split the completion by direction
    assign read_done_o[i]  = done_v_lo & ~done_lo.wnr;
    assign write_done_o[i] = done_v_lo & done_lo.wnr;
    assign done_addr_o[i]  = done_lo.addr;

    // storage is written at acceptance
    assign write_v_li = yumi_o[i] & req_i[i].wnr;

    dram_channel_mem i_mem (
      .clk_i    (clk_i),
      .w_v_i    (write_v_li),
      .w_addr_i (req_i[i].addr),
      .w_data_i (req_i[i].data),
      .w_mask_i (req_i[i].mask),
      .r_v_i    (read_done_o[i]),
      .r_addr_i (done_lo.addr),
      .r_data_o (data_o[i])
    );

    dram_channel_stats i_stats (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .accept_i (yumi_o[i]),
      .write_i  (req_i[i].wnr),
      .hit_i    (hit_lo),
      .stat_v_i (stat_v_i),
      .stats_o  (stats_o[i])
    );
  end

  // read valid and address line up with the storage output
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_v_o <= '0;
    end else begin
      data_v_o <= read_done_o;
    end
    for (int ch = 0; ch < `DRAM_NUM_CH; ch++) begin
      if (read_done_o[ch]) begin
        read_addr_o[ch] <= done_addr_o[ch];
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_dram_table.svh ====
`ifndef TB_DRAM_TABLE_SVH
`define TB_DRAM_TABLE_SVH

// columns: ch, wnr, addr, data, mask, data-valid delay, wait for completion, expected read data
// addr split: [15:8] row, [7:6] bank, [5:2] col

localparam int TABLE_LEN = 23;

table_entry_t tbl [TABLE_LEN];

task automatic load_table();
  // full and masked writes to one word, then reads
  tbl[0]  = '{8'd0, 1'b1, 16'h0100, 32'h11223344, 4'hf, 8'd0, 1'b1, 32'h0};
  tbl[1]  = '{8'd0, 1'b0, 16'h0100, 32'h0, 4'h0, 8'd0, 1'b1, 32'h11223344};
  tbl[2]  = '{8'd0, 1'b1, 16'h0100, 32'haabbccdd, 4'h5, 8'd0, 1'b1, 32'h0};
  tbl[3]  = '{8'd0, 1'b0, 16'h0100, 32'h0, 4'h0, 8'd0, 1'b1, 32'h11bb33dd};
  tbl[4]  = '{8'd0, 1'b1, 16'h0100, 32'h01020304, 4'ha, 8'd0, 1'b1, 32'h0};
  tbl[5]  = '{8'd0, 1'b0, 16'h0100, 32'h0, 4'h0, 8'd0, 1'b1, 32'h01bb03dd};
  // other row in bank 0, then back again
  tbl[6]  = '{8'd0, 1'b1, 16'h0200, 32'hcafef00d, 4'hf, 8'd0, 1'b1, 32'h0};
  tbl[7]  = '{8'd0, 1'b0, 16'h0100, 32'h0, 4'h0, 8'd0, 1'b1, 32'h01bb03dd};
  tbl[8]  = '{8'd0, 1'b0, 16'h0200, 32'h0, 4'h0, 8'd0, 1'b1, 32'hcafef00d};
  // bank 1
  tbl[9]  = '{8'd0, 1'b1, 16'h0240, 32'h0badcafe, 4'hf, 8'd0, 1'b1, 32'h0};
  tbl[10] = '{8'd0, 1'b0, 16'h0240, 32'h0, 4'h0, 8'd0, 1'b1, 32'h0badcafe};
  // back to back, fills the queue
  tbl[11] = '{8'd0, 1'b1, 16'h0104, 32'h10000001, 4'hf, 8'd0, 1'b0, 32'h0};
  tbl[12] = '{8'd0, 1'b1, 16'h0108, 32'h20000002, 4'hf, 8'd0, 1'b0, 32'h0};
  tbl[13] = '{8'd0, 1'b0, 16'h0104, 32'h0, 4'h0, 8'd0, 1'b0, 32'h10000001};
  tbl[14] = '{8'd0, 1'b0, 16'h0108, 32'h0, 4'h0, 8'd0, 1'b0, 32'h20000002};
  tbl[15] = '{8'd0, 1'b1, 16'h0280, 32'h30000003, 4'hf, 8'd0, 1'b0, 32'h0};
  tbl[16] = '{8'd0, 1'b0, 16'h0280, 32'h0, 4'h0, 8'd0, 1'b1, 32'h30000003};
  // write data arrives late
  tbl[17] = '{8'd0, 1'b1, 16'h010c, 32'h12345678, 4'hf, 8'd5, 1'b1, 32'h0};
  tbl[18] = '{8'd0, 1'b0, 16'h010c, 32'h0, 4'h0, 8'd0, 1'b1, 32'h12345678};
  // channel 1 keeps its own storage
  tbl[19] = '{8'd1, 1'b1, 16'h0100, 32'h87654321, 4'hf, 8'd0, 1'b1, 32'h0};
  tbl[20] = '{8'd1, 1'b0, 16'h0100, 32'h0, 4'h0, 8'd0, 1'b1, 32'h87654321};
  tbl[21] = '{8'd1, 1'b1, 16'h0300, 32'hdeadbeef, 4'hf, 8'd3, 1'b0, 32'h0};
  tbl[22] = '{8'd1, 1'b0, 16'h0300, 32'h0, 4'h0, 8'd0, 1'b1, 32'hdeadbeef};
endtask

`endif

// ==== tb_dram_model.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dram_config.svh"

module tb_dram_model
  import dram_pkg::*;
  ;

  localparam int NCH    = `DRAM_NUM_CH;
  localparam int DEPTH  = `DRAM_QUEUE_DEPTH;
  localparam int RAND_N = 40;

  typedef struct packed {
    logic [7:0]  ch;
    logic        wnr;
    logic [15:0] addr;
    logic [31:0] data;
    logic [3:0]  mask;
    logic [7:0]  dv_delay;
    logic        wait_done;
    logic [31:0] exp;
  } table_entry_t;

  `include "tb_dram_table.svh"

  localparam int LIMIT = (TABLE_LEN + RAND_N) * (`DRAM_T_MISS + 50);

  logic                                       clk_i = 1'b0;
  logic                                       reset_i;
  logic        [NCH-1:0]                      v_i;
  logic        [NCH-1:0]                      data_v_i;
  dram_req_t   [NCH-1:0]                      req_i;
  logic        [NCH-1:0]                      yumi_o;
  logic        [NCH-1:0]                      read_done_o;
  logic        [NCH-1:0]                      write_done_o;
  logic        [NCH-1:0][`DRAM_ADDR_W-1:0]    done_addr_o;
  logic        [NCH-1:0]                      data_v_o;
  logic        [NCH-1:0][`DRAM_DATA_W-1:0]    data_o;
  logic        [NCH-1:0][`DRAM_ADDR_W-1:0]    read_addr_o;
  logic                                       stat_v_i;
  dram_stats_t [NCH-1:0]                      stats_o;

  // reference model state
  dram_done_t  exp_q [NCH][$];
  int          due_q [NCH][$];
  int          last_due [NCH];
  logic        bank_open [NCH][4];
  logic [7:0]  open_row [NCH][4];
  logic [31:0] img [NCH][1 << 14];
  logic        rd_pend [NCH];
  logic [31:0] rd_data [NCH];
  logic [15:0] rd_addr [NCH];
  dram_stats_t model_stats [NCH];
  int          cyc;
  int          tick;
  logic [31:0] rnd_state;

  dram_model i_dram_model (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_bit(input string name, input int ch, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s ch%0d: got %h expected %h", name, ch, got, exp);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_word(input string name, input int ch, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s ch%0d: got %h expected %h", name, ch, got, exp);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_done(input string name, input int ch, input dram_done_t got,
                            input dram_done_t exp);
    if (got !== exp) begin
      $display("mismatch %s ch%0d: got %h expected %h", name, ch, got, exp);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_stats(input string name, input int ch, input dram_stats_t got,
                             input dram_stats_t exp);
    if (got !== exp) begin
      $display("mismatch %s ch%0d: got %h expected %h", name, ch, got, exp);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  // one channel per cycle, sampled mid-cycle where outputs are settled
  task automatic monitor_channel(input int ch);
    logic       exp_yumi;
    logic       head_due;
    logic       hit;
    dram_done_t got;
    dram_done_t head;
    logic [7:0] row;
    logic [1:0] bank;
    int         due;
    exp_yumi = v_i[ch] && (exp_q[ch].size() < DEPTH) && (!req_i[ch].wnr || data_v_i[ch]);
    check_bit("yumi_o", ch, yumi_o[ch], exp_yumi);
    check_bit("data_v_o", ch, data_v_o[ch], rd_pend[ch]);
    if (rd_pend[ch]) begin
      check_word("data_o", ch, data_o[ch], rd_data[ch]);
      check_word("read_addr_o", ch, {16'h0, read_addr_o[ch]}, {16'h0, rd_addr[ch]});
    end
    rd_pend[ch] = 1'b0;
    head_due = (exp_q[ch].size() > 0) && (due_q[ch][0] == cyc);
    check_bit("read_done_o|write_done_o", ch, read_done_o[ch] | write_done_o[ch], head_due);
    if (head_due) begin
      head = exp_q[ch].pop_front();
      due  = due_q[ch].pop_front();
      got  = '{wnr: write_done_o[ch], addr: done_addr_o[ch]};
      check_done("done", ch, got, head);
      if (!head.wnr) begin
        rd_pend[ch] = 1'b1;
        rd_data[ch] = img[ch][head.addr[15:2]];
        rd_addr[ch] = head.addr;
      end
    end
    if (exp_yumi) begin
      row  = req_i[ch].addr[15:8];
      bank = req_i[ch].addr[7:6];
      hit  = bank_open[ch][bank] && (open_row[ch][bank] == row);
      due  = cyc + (hit ? `DRAM_T_HIT : `DRAM_T_MISS);
      if (last_due[ch] + 1 > due) begin
        due = last_due[ch] + 1;
      end
      last_due[ch] = due;
      exp_q[ch].push_back('{wnr: req_i[ch].wnr, addr: req_i[ch].addr});
      due_q[ch].push_back(due);
      bank_open[ch][bank] = 1'b1;
      open_row[ch][bank]  = row;
      if (hit) begin
        model_stats[ch].hits = model_stats[ch].hits + 16'd1;
      end
      if (req_i[ch].wnr) begin
        model_stats[ch].writes = model_stats[ch].writes + 16'd1;
        for (int b = 0; b < 4; b++) begin
          if (req_i[ch].mask[b]) begin
            img[ch][req_i[ch].addr[15:2]][8*b +: 8] = req_i[ch].data[8*b +: 8];
          end
        end
      end else begin
        model_stats[ch].reads = model_stats[ch].reads + 16'd1;
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (reset_i) begin
      cyc = 0;
      for (int ch = 0; ch < NCH; ch++) begin
        check_bit("yumi_o", ch, yumi_o[ch], 1'b0);
        check_bit("read_done_o", ch, read_done_o[ch], 1'b0);
        check_bit("write_done_o", ch, write_done_o[ch], 1'b0);
        check_bit("data_v_o", ch, data_v_o[ch], 1'b0);
      end
    end else begin
      for (int ch = 0; ch < NCH; ch++) begin
        monitor_channel(ch);
      end
      cyc = cyc + 1;
    end
  end

  always @(posedge clk_i) begin
    tick = tick + 1;
    if (tick > LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("TEST FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic wait_idle(input int ch);
    while (exp_q[ch].size() != 0 || rd_pend[ch]) begin
      @(negedge clk_i);
      #1;
    end
  endtask

  task automatic drive_entry(input table_entry_t e);
    int   ch;
    int   k;
    logic taken;
    ch = int'(e.ch);
    @(posedge clk_i);
    #2;
    v_i                = '0;
    data_v_i           = '0;
    v_i[ch]            = 1'b1;
    data_v_i[ch]       = (e.dv_delay == 8'd0);
    req_i[ch]          = '{wnr: e.wnr, addr: e.addr, data: e.data, mask: e.mask};
    k     = 0;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      #1;
      if (yumi_o[ch]) begin
        taken = 1'b1;
      end else begin
        k = k + 1;
        @(posedge clk_i);
        #2;
        if (k >= int'(e.dv_delay)) begin
          data_v_i[ch] = 1'b1;
        end
      end
    end
    if (e.wait_done) begin
      @(posedge clk_i);
      #2;
      v_i      = '0;
      data_v_i = '0;
      wait_idle(ch);
      if (!e.wnr) begin
        check_word("data_o", ch, data_o[ch], e.exp);
        check_word("read_addr_o", ch, {16'h0, read_addr_o[ch]}, {16'h0, e.addr});
      end
    end
  endtask

  task automatic pulse_stats();
    for (int ch = 0; ch < NCH; ch++) begin
      wait_idle(ch);
    end
    @(posedge clk_i);
    #2;
    stat_v_i = 1'b1;
    @(posedge clk_i);
    #2;
    stat_v_i = 1'b0;
    @(negedge clk_i);
    for (int ch = 0; ch < NCH; ch++) begin
      check_stats("stats_o", ch, stats_o[ch], model_stats[ch]);
    end
  endtask

  task automatic random_phase();
    int       sent [NCH];
    logic     active [NCH];
    logic     written [NCH][256];
    logic [7:0] key;
    logic     wnr;
    for (int ch = 0; ch < NCH; ch++) begin
      sent[ch]   = 0;
      active[ch] = 1'b0;
      for (int w = 0; w < 256; w++) begin
        written[ch][w] = 1'b0;
      end
    end
    while (sent[0] < RAND_N || sent[1] < RAND_N || active[0] || active[1]) begin
      @(posedge clk_i);
      #2;
      for (int ch = 0; ch < NCH; ch++) begin
        if (!active[ch] && sent[ch] < RAND_N) begin
          rnd_state = xorshift32(rnd_state);
          key = rnd_state[8:1];
          // first touch of an address is a full write
          wnr = rnd_state[0] | !written[ch][key];
          req_i[ch].wnr  = wnr;
          req_i[ch].addr = {5'b0, ch[0], key, 2'b00};
          req_i[ch].mask = written[ch][key] ? rnd_state[12:9] : 4'hf;
          rnd_state = xorshift32(rnd_state);
          req_i[ch].data = rnd_state;
          if (wnr) begin
            written[ch][key] = 1'b1;
          end
          active[ch] = 1'b1;
        end
        if (active[ch]) begin
          rnd_state    = xorshift32(rnd_state);
          v_i[ch]      = 1'b1;
          data_v_i[ch] = rnd_state[3];
        end else begin
          v_i[ch]      = 1'b0;
          data_v_i[ch] = 1'b0;
        end
      end
      @(negedge clk_i);
      #1;
      for (int ch = 0; ch < NCH; ch++) begin
        if (active[ch] && yumi_o[ch]) begin
          active[ch] = 1'b0;
          sent[ch]   = sent[ch] + 1;
        end
      end
    end
    @(posedge clk_i);
    #2;
    v_i      = '0;
    data_v_i = '0;
  endtask

  initial begin
    reset_i   = 1'b1;
    v_i       = '0;
    data_v_i  = '0;
    req_i     = '0;
    stat_v_i  = 1'b0;
    tick      = 0;
    cyc       = 0;
    rnd_state = 32'd55;
    for (int ch = 0; ch < NCH; ch++) begin
      last_due[ch]    = 0;
      rd_pend[ch]     = 1'b0;
      model_stats[ch] = '0;
      for (int b = 0; b < 4; b++) begin
        bank_open[ch][b] = 1'b0;
        open_row[ch][b]  = 8'h0;
      end
    end
    load_table();
    repeat (16) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    for (int i = 0; i < TABLE_LEN; i++) begin
      drive_entry(tbl[i]);
    end
    @(posedge clk_i);
    #2;
    v_i      = '0;
    data_v_i = '0;
    pulse_stats();
    random_phase();
    pulse_stats();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
dram_pkg.sv
dram_channel_timing.sv
dram_channel_mem.sv
dram_channel_stats.sv
dram_model.sv
tb_dram_model.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the DRAM model testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_dram_model -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
  exit 1
fi
exit 0
